// ==== all.f ====
+incdir+design
design/sched_pkg.sv
design/sched_fifo.sv
design/slot_keeper.sv
design/slot_pool.sv
design/desc_allocator.sv
design/sched_host_regs.sv
design/rx_scheduler.sv
dv/rx_scheduler_tb.sv

// ==== design/desc_allocator.sv ====
`timescale 1ns/1ps
`include "sched_config.svh"

module desc_allocator (
  input  logic                                     clk,
  input  logic                                     rst_r,
  input  sched_pkg::if_mask_t                      hash_valid,
  input  sched_pkg::hash_t [`SCHED_IF_COUNT-1:0]   hashes,
  output sched_pkg::if_mask_t                      hash_pop,
  input  sched_pkg::if_mask_t                      out_ready,
  output sched_pkg::if_mask_t                      out_push,
  output sched_pkg::desc_t                         out_desc,
  input  sched_pkg::slot_t [`SCHED_CORE_COUNT-1:0] heads,
  input  sched_pkg::core_mask_t                    head_valid,
  input  sched_pkg::core_mask_t                    income,
  input  sched_pkg::if_mask_t                      almost_full,
  output sched_pkg::core_mask_t                    take,
  output logic [`SCHED_IF_COUNT-1:0][31:0]         drop_counts
);
  import sched_pkg::*;

  if_mask_t req;
  if_mask_t grant;
  if_id_t   grant_id;
  logic     grant_v;
  if_id_t   last_id;
  if_mask_t grant_r;
  if_id_t   grant_id_r;
  core_id_t core_r;
  logic     busy;
  logic     take_ok;
  logic     do_drop;

  // An interface granted last cycle sits out while its decision completes
  assign req = hash_valid & ~grant_r & out_ready;

  // Round robin, searching from the interface after the last winner
  always_comb begin
    int idx;
    grant    = '0;
    grant_id = last_id;
    grant_v  = 1'b0;
    for (int k = 1; k <= `SCHED_IF_COUNT; k++) begin
      idx = (int'(last_id) + k) % `SCHED_IF_COUNT;
      if (!grant_v && req[idx]) begin
        grant    = if_mask_t'(1) << idx;
        grant_id = if_id_t'(idx);
        grant_v  = 1'b1;
      end
    end
  end

  // Cycle 1 registers the winner and its destination core
  always_ff @(posedge clk) begin
    if (rst_r) begin
      last_id    <= '0;
      grant_r    <= '0;
      grant_id_r <= '0;
      core_r     <= '0;
    end else begin
      // grant_id holds last_id when nothing wins
      last_id    <= grant_id;
      grant_r    <= grant;
      grant_id_r <= grant_id;
      core_r     <= hashes[grant_id][`SCHED_HASH_SEL_OFFSET +: $bits(core_id_t)];
    end
  end

  // Cycle 2 takes a slot, drops under pressure, or leaves the hash for a retry
  assign busy     = |grant_r;
  assign take_ok  = busy && head_valid[core_r] && income[core_r];
  assign do_drop  = busy && !take_ok && almost_full[grant_id_r];
  assign out_push = (take_ok || do_drop) ? grant_r : '0;
  assign hash_pop = out_push;
  assign take     = take_ok ? (core_mask_t'(1) << core_r) : '0;
  assign out_desc = '{drop: do_drop, hash: hashes[grant_id_r], core: core_r,
                      slot: heads[core_r]};

  always_ff @(posedge clk) begin
    if (rst_r) begin
      drop_counts <= '0;
    end else if (do_drop) begin
      drop_counts[grant_id_r] <= drop_counts[grant_id_r] + 32'd1;
    end
  end

  assert property (@(posedge clk) disable iff (rst_r) $onehot0(out_push));

  // Room was checked a cycle before the push, the FIFO must still have it
  assert property (@(posedge clk) disable iff (rst_r) (out_push & ~out_ready) == '0);

endmodule

// ==== design/rx_scheduler.sv ====
`timescale 1ns/1ps
`include "sched_config.svh"

module rx_scheduler (
  input  logic                                         clk,
  input  logic                                         rst_r,
  input  sched_pkg::hash_t [`SCHED_IF_COUNT-1:0]       hash,
  input  sched_pkg::if_mask_t                          hash_valid,
  output sched_pkg::if_mask_t                          hash_ready,
  output sched_pkg::desc_t [`SCHED_IF_COUNT-1:0]       desc,
  output sched_pkg::if_mask_t                          desc_valid,
  input  sched_pkg::if_mask_t                          desc_ready,
  input  sched_pkg::line_count_t [`SCHED_IF_COUNT-1:0] line_count,
  input  sched_pkg::ctrl_msg_t                         ctrl_msg,
  input  sched_pkg::core_id_t                          ctrl_core,
  input  logic                                         ctrl_valid,
  input  sched_pkg::host_cmd_t                         host_cmd,
  input  logic [31:0]                                  host_wr_data,
  input  logic                                         host_cmd_valid,
  output logic [31:0]                                  host_rd_data,
  output logic                                         slot_err
);
  import sched_pkg::*;

  hash_t [`SCHED_IF_COUNT-1:0]   hash_f;
  if_mask_t                      hash_f_valid;
  if_mask_t                      hash_pop;
  if_mask_t                      desc_push;
  if_mask_t                      desc_in_ready;
  if_mask_t                      almost_full;
  desc_t                         alloc_desc;
  slot_t [`SCHED_CORE_COUNT-1:0] heads;
  slot_t [`SCHED_CORE_COUNT-1:0] counts;
  core_mask_t                    head_valid;
  core_mask_t                    take;
  core_mask_t                    income;
  core_mask_t                    flush;
  logic [`SCHED_IF_COUNT-1:0][31:0] drop_counts;

  for (genvar i = 0; i < `SCHED_IF_COUNT; i++) begin : g_if
    sched_fifo #(.DEPTH(`SCHED_HASH_FIFO_DEPTH), .WIDTH($bits(hash_t))) hash_fifo_i (
      .clk       (clk),
      .rst_r     (rst_r),
      .in_data   (hash[i]),
      .in_valid  (hash_valid[i]),
      .in_ready  (hash_ready[i]),
      .out_data  (hash_f[i]),
      .out_valid (hash_f_valid[i]),
      .out_ready (hash_pop[i])
    );

    // All descriptor FIFOs see the same descriptor, only one is pushed
    sched_fifo #(.DEPTH(`SCHED_DESC_FIFO_DEPTH), .WIDTH($bits(desc_t))) desc_fifo_i (
      .clk       (clk),
      .rst_r     (rst_r),
      .in_data   (alloc_desc),
      .in_valid  (desc_push[i]),
      .in_ready  (desc_in_ready[i]),
      .out_data  (desc[i]),
      .out_valid (desc_valid[i]),
      .out_ready (desc_ready[i])
    );
  end

  desc_allocator alloc_i (
    .clk         (clk),
    .rst_r       (rst_r),
    .hash_valid  (hash_f_valid),
    .hashes      (hash_f),
    .hash_pop    (hash_pop),
    .out_ready   (desc_in_ready),
    .out_push    (desc_push),
    .out_desc    (alloc_desc),
    .heads       (heads),
    .head_valid  (head_valid),
    .income      (income),
    .almost_full (almost_full),
    .take        (take),
    .drop_counts (drop_counts)
  );

  slot_pool pool_i (
    .clk        (clk),
    .rst_r      (rst_r),
    .ctrl_msg   (ctrl_msg),
    .ctrl_core  (ctrl_core),
    .ctrl_valid (ctrl_valid),
    .flush      (flush),
    .take       (take),
    .heads      (heads),
    .head_valid (head_valid),
    .counts     (counts),
    .slot_err   (slot_err)
  );

  sched_host_regs regs_i (
    .clk            (clk),
    .rst_r          (rst_r),
    .host_cmd       (host_cmd),
    .host_wr_data   (host_wr_data),
    .host_cmd_valid (host_cmd_valid),
    .host_rd_data   (host_rd_data),
    .line_count     (line_count),
    .enabled        (),
    .income         (income),
    .flush          (flush),
    .almost_full    (almost_full),
    .counts         (counts),
    .drop_counts    (drop_counts)
  );

endmodule

// ==== design/sched_config.svh ====
`ifndef SCHED_CONFIG_SVH
`define SCHED_CONFIG_SVH

// Scheduler sizes
`define SCHED_IF_COUNT        3
`define SCHED_CORE_COUNT      8
`define SCHED_SLOT_COUNT      32
`define SCHED_HASH_FIFO_DEPTH 16
`define SCHED_DESC_FIFO_DEPTH 4

// Field widths
`define SCHED_IF_ID_WIDTH     2
`define SCHED_CORE_ID_WIDTH   3
`define SCHED_SLOT_WIDTH      6
`define SCHED_HASH_WIDTH      32
`define SCHED_LINES_WIDTH     13

// Core index starts at this hash bit
`define SCHED_HASH_SEL_OFFSET 0
`define SCHED_DROP_LIMIT_RST  13'd3584

// Control message types handled by the slot pool
`define SCHED_MSG_SLOT_RETURN 4'd0
`define SCHED_MSG_SLOT_INIT   4'd3

// Host registers on the core side
`define SCHED_REG_ENABLED     4'd0
`define SCHED_REG_INCOME      4'd1
`define SCHED_REG_FLUSH       4'd2
`define SCHED_REG_SLOT_COUNT  4'd3
// Host registers on the interface side
`define SCHED_REG_DROP_COUNT  4'd2
`define SCHED_REG_DROP_LIMIT  4'd3

`define SCHED_RD_DEFAULT      32'hFEFEFEFE

`endif

// ==== design/sched_fifo.sv ====
`timescale 1ns/1ps

module sched_fifo #(
  parameter int DEPTH = 4,
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst_r,
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output logic [WIDTH-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Count and pointers stay in step and the count never passes the depth
  assert property (@(posedge clk) disable iff (rst_r)
    (count <= CNT_W'(DEPTH)) &&
    ((wr_ptr == rd_ptr) == ((count == '0) || (count == CNT_W'(DEPTH)))));

endmodule

// ==== design/sched_host_regs.sv ====
`timescale 1ns/1ps
`include "sched_config.svh"

module sched_host_regs (
  input  logic                                         clk,
  input  logic                                         rst_r,
  input  sched_pkg::host_cmd_t                         host_cmd,
  input  logic [31:0]                                  host_wr_data,
  input  logic                                         host_cmd_valid,
  output logic [31:0]                                  host_rd_data,
  input  sched_pkg::line_count_t [`SCHED_IF_COUNT-1:0] line_count,
  output sched_pkg::core_mask_t                        enabled,
  output sched_pkg::core_mask_t                        income,
  output sched_pkg::core_mask_t                        flush,
  output sched_pkg::if_mask_t                          almost_full,
  input  sched_pkg::slot_t [`SCHED_CORE_COUNT-1:0]     counts,
  input  logic [`SCHED_IF_COUNT-1:0][31:0]             drop_counts
);
  import sched_pkg::*;

  host_cmd_t                         cmd_r;
  logic [31:0]                       wr_data_r;
  logic                              wr_r;
  core_mask_t                        wr_mask;
  core_id_t                          rd_core;
  if_id_t                            rd_if;
  line_count_t [`SCHED_IF_COUNT-1:0] line_count_r;
  line_count_t                       drop_limit;

  assign wr_mask = wr_data_r[$bits(core_mask_t)-1:0];
  assign rd_core = cmd_r.index[$bits(core_id_t)-1:0];
  assign rd_if   = cmd_r.index[$bits(if_id_t)-1:0];

  always_ff @(posedge clk) begin
    cmd_r        <= host_cmd;
    wr_data_r    <= host_wr_data;
    line_count_r <= line_count;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_r       <= 1'b0;
      enabled    <= '0;
      income     <= '0;
      flush      <= '0;
      drop_limit <= `SCHED_DROP_LIMIT_RST;
    end else begin
      wr_r  <= host_cmd_valid && host_cmd.wr && host_cmd.to_sched;
      flush <= '0;
      if (wr_r && !cmd_r.to_int) begin
        case (cmd_r.reg_sel)
          `SCHED_REG_ENABLED: begin
            // A core leaving the enabled set stops taking traffic too
            enabled <= wr_mask;
            income  <= income & wr_mask;
          end
          `SCHED_REG_INCOME: income <= wr_mask & enabled;
          `SCHED_REG_FLUSH:  flush  <= wr_mask;
          default: ;
        endcase
      end
      if (wr_r && cmd_r.to_int && (cmd_r.reg_sel == `SCHED_REG_DROP_LIMIT)) begin
        drop_limit <= wr_data_r[$bits(line_count_t)-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      almost_full <= '0;
    end else begin
      for (int i = 0; i < `SCHED_IF_COUNT; i++) begin
        almost_full[i] <= (line_count_r[i] >= drop_limit);
      end
    end
  end

  // Readback follows the registered command
  always_ff @(posedge clk) begin
    host_rd_data <= `SCHED_RD_DEFAULT;
    if (!cmd_r.to_int) begin
      case (cmd_r.reg_sel)
        `SCHED_REG_ENABLED:    host_rd_data <= 32'(enabled);
        `SCHED_REG_INCOME:     host_rd_data <= 32'(income);
        `SCHED_REG_SLOT_COUNT: host_rd_data <= 32'(counts[rd_core]);
        default: ;
      endcase
    end else if ((cmd_r.reg_sel == `SCHED_REG_DROP_COUNT) &&
                 (cmd_r.index < `SCHED_IF_COUNT)) begin
      host_rd_data <= drop_counts[rd_if];
    end
  end

  // Income stays a subset of enabled across any order of writes
  assert property (@(posedge clk) disable iff (rst_r) (income & ~enabled) == '0);

endmodule

// ==== design/sched_pkg.sv ====
`include "sched_config.svh"

package sched_pkg;

  // Indices, masks and counts
  typedef logic [`SCHED_IF_ID_WIDTH-1:0]   if_id_t;
  typedef logic [`SCHED_CORE_ID_WIDTH-1:0] core_id_t;
  typedef logic [`SCHED_CORE_COUNT-1:0]    core_mask_t;
  typedef logic [`SCHED_IF_COUNT-1:0]      if_mask_t;
  typedef logic [`SCHED_SLOT_WIDTH-1:0]    slot_t;
  typedef logic [`SCHED_HASH_WIDTH-1:0]    hash_t;
  typedef logic [`SCHED_LINES_WIDTH-1:0]   line_count_t;

  // Per-interface descriptor, drop flag on top
  typedef struct packed {
    logic     drop;
    hash_t    hash;
    core_id_t core;
    slot_t    slot;
  } desc_t;

  // Core control message, slot field starts at bit 16
  typedef struct packed {
    logic [3:0]  msg_type;
    logic [9:0]  reserved;
    slot_t       slot;
    logic [15:0] unused;
  } ctrl_msg_t;

  // Host command word
  typedef struct packed {
    logic        wr;
    logic        to_int;
    logic        to_sched;
    logic [20:0] spare;
    logic [3:0]  index;
    logic [3:0]  reg_sel;
  } host_cmd_t;

endpackage

// ==== design/slot_keeper.sv ====
`timescale 1ns/1ps
`include "sched_config.svh"

module slot_keeper (
  input  logic             clk,
  input  logic             rst_r,
  input  logic             flush,
  input  logic             init_valid,
  input  logic             return_valid,
  input  sched_pkg::slot_t slot_in,
  output sched_pkg::slot_t head,
  output logic             head_valid,
  input  logic             take,
  output sched_pkg::slot_t count,
  output logic             enq_err
);
  import sched_pkg::*;

  localparam int    PTR_W = $clog2(`SCHED_SLOT_COUNT);
  localparam slot_t FULL  = slot_t'(`SCHED_SLOT_COUNT);

  slot_t            mem [`SCHED_SLOT_COUNT];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  slot_t            init_n;
  logic             enq;

  // Oversized init requests fill the whole ring
  assign init_n     = (slot_in > FULL) ? FULL : slot_in;
  assign enq        = return_valid && (count != FULL);
  assign enq_err    = return_valid && (count == FULL);
  assign head       = mem[rd_ptr];
  assign head_valid = (count != '0);

  // Init lays out slots 1 to N from the bottom of the ring
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < `SCHED_SLOT_COUNT; i++) begin
        mem[i] <= slot_t'(i + 1);
      end
    end else if (enq) begin
      mem[wr_ptr] <= slot_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (init_valid) begin
      rd_ptr <= '0;
      wr_ptr <= PTR_W'(init_n);
      count  <= init_n;
    end else begin
      // Ring of 32 entries, pointers wrap on their own
      if (enq) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (take) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + slot_t'(enq) - slot_t'(take);
    end
  end

  // The allocator only takes from a keeper that shows a slot
  assert property (@(posedge clk) disable iff (rst_r) take |-> head_valid);

endmodule

// ==== design/slot_pool.sv ====
`timescale 1ns/1ps
`include "sched_config.svh"

module slot_pool (
  input  logic                                     clk,
  input  logic                                     rst_r,
  input  sched_pkg::ctrl_msg_t                     ctrl_msg,
  input  sched_pkg::core_id_t                      ctrl_core,
  input  logic                                     ctrl_valid,
  input  sched_pkg::core_mask_t                    flush,
  input  sched_pkg::core_mask_t                    take,
  output sched_pkg::slot_t [`SCHED_CORE_COUNT-1:0] heads,
  output sched_pkg::core_mask_t                    head_valid,
  output sched_pkg::slot_t [`SCHED_CORE_COUNT-1:0] counts,
  output logic                                     slot_err
);
  import sched_pkg::*;

  core_mask_t core_sel;
  core_mask_t init_r;
  core_mask_t return_r;
  core_mask_t enq_err;
  slot_t      slot_r;

  assign core_sel = ctrl_valid ? (core_mask_t'(1) << ctrl_core) : '0;

  // One register stage between the control input and the keepers
  always_ff @(posedge clk) begin
    if (rst_r) begin
      init_r   <= '0;
      return_r <= '0;
      slot_err <= 1'b0;
    end else begin
      init_r   <= (ctrl_msg.msg_type == `SCHED_MSG_SLOT_INIT) ? core_sel : '0;
      return_r <= (ctrl_msg.msg_type == `SCHED_MSG_SLOT_RETURN) ? core_sel : '0;
      slot_err <= |enq_err;
    end
  end

  // Slot number for a return, or the pool size for an init
  always_ff @(posedge clk) begin
    slot_r <= ctrl_msg.slot;
  end

  for (genvar c = 0; c < `SCHED_CORE_COUNT; c++) begin : g_keeper
    slot_keeper keeper_i (
      .clk          (clk),
      .rst_r        (rst_r),
      .flush        (flush[c]),
      .init_valid   (init_r[c]),
      .return_valid (return_r[c]),
      .slot_in      (slot_r),
      .head         (heads[c]),
      .head_valid   (head_valid[c]),
      .take         (take[c]),
      .count        (counts[c]),
      .enq_err      (enq_err[c])
    );
  end

endmodule

// ==== dv/rx_scheduler_tb.sv ====
`timescale 1ns/1ps
`include "sched_config.svh"

module rx_scheduler_tb;
  import sched_pkg::*;

  localparam int IFS   = `SCHED_IF_COUNT;
  localparam int CORES = `SCHED_CORE_COUNT;
  // Cycle budget of each test in the order the tests run
  localparam int TEST_CYCLES = 120 + 300 + 400 + 300 + 800 + 250;
  localparam int DRAIN_LIMIT = 400;

  logic                          clk;
  logic                          rst_r;
  hash_t [IFS-1:0]               hash;
  if_mask_t                      hash_valid;
  if_mask_t                      hash_ready;
  desc_t [IFS-1:0]               desc;
  if_mask_t                      desc_valid;
  if_mask_t                      desc_ready;
  line_count_t [IFS-1:0]         line_count;
  ctrl_msg_t                     ctrl_msg;
  core_id_t                      ctrl_core;
  logic                          ctrl_valid;
  host_cmd_t                     host_cmd;
  logic [31:0]                   host_wr_data;
  logic                          host_cmd_valid;
  logic [31:0]                   host_rd_data;
  logic                          slot_err;

  // Reference model state
  logic [31:0] lfsr;
  int          free_q [CORES][$];
  hash_t       pend_q [IFS][$];
  int          in_count [IFS];
  int          out_count [IFS];
  if_mask_t    took;
  if_mask_t    drop_expect;
  int          err_pulses;
  int          err_expect;
  bit          exact_slots;
  bit          ready_random;
  string       test_name;

  rx_scheduler dut_i (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("FAIL %s %s expected %0h actual %0h", test_name, what, exp, act);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  // Galois LFSR stepped once per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int b = 0; b < n; b++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
  endfunction

  // A negative core leaves the hash fully random
  function automatic hash_t make_hash(input int core);
    hash_t h;
    h = rand_bits(32);
    if (core >= 0) begin
      h[`SCHED_HASH_SEL_OFFSET +: $bits(core_id_t)] = core_id_t'(core);
    end
    return h;
  endfunction

  function automatic int pending();
    int sum;
    sum = 0;
    for (int i = 0; i < IFS; i++) begin
      sum += pend_q[i].size();
    end
    return sum;
  endfunction

  task automatic check_desc(input int i, input desc_t d);
    hash_t exp_hash;
    int    c;
    int    pos;
    int    exp_slot;
    assert (pend_q[i].size() != 0)
      else abort_run($sformatf("descriptor on interface %0d with no accepted hash", i));
    exp_hash = pend_q[i].pop_front();
    c = int'(exp_hash[`SCHED_HASH_SEL_OFFSET +: $bits(core_id_t)]);
    assert (d.hash == exp_hash) else report_mismatch("hash", exp_hash, d.hash);
    assert (int'(d.core) == c) else report_mismatch("core", c, d.core);
    assert (d.drop == drop_expect[i]) else report_mismatch("drop", drop_expect[i], d.drop);
    if (!d.drop && exact_slots) begin
      assert (free_q[c].size() != 0) else abort_run("slot handed out by a core with none free");
      exp_slot = free_q[c].pop_front();
      assert (int'(d.slot) == exp_slot) else report_mismatch("slot", exp_slot, d.slot);
    end else if (!d.drop) begin
      // Stalled FIFOs reorder takes across interfaces and only membership holds
      pos = -1;
      for (int k = 0; k < free_q[c].size(); k++) begin
        if (pos < 0 && free_q[c][k] == int'(d.slot)) begin
          pos = k;
        end
      end
      assert (pos >= 0) else abort_run($sformatf("slot %0d of core %0d is not free", d.slot, c));
      free_q[c].delete(pos);
    end
    out_count[i]++;
  endtask

  // Handshakes are seen at the rising edge before any register updates
  always @(posedge clk) begin
    if (!rst_r) begin
      for (int i = 0; i < IFS; i++) begin
        took[i] = hash_valid[i] && hash_ready[i];
        if (took[i]) begin
          pend_q[i].push_back(hash[i]);
          in_count[i]++;
        end
        if (desc_valid[i] && desc_ready[i]) begin
          check_desc(i, desc[i]);
        end
      end
      if (slot_err) begin
        err_pulses++;
      end
    end
  end

  for (genvar g = 0; g < IFS; g++) begin : g_hold
    assert property (@(posedge clk) disable iff (rst_r)
      (desc_valid[g] && !desc_ready[g]) |=> (desc_valid[g] && $stable(desc[g])))
      else abort_run($sformatf("descriptor on interface %0d changed while stalled", g));
  end

  task automatic next_cycle();
    @(negedge clk);
    desc_ready = ready_random ? if_mask_t'(rand_bits(IFS)) : '1;
  endtask

  task automatic host_write(input bit to_int, input logic [3:0] sel, input logic [3:0] index,
                            input logic [31:0] data);
    next_cycle();
    host_cmd = '{wr: 1'b1, to_int: to_int, to_sched: 1'b1, spare: '0, index: index,
                 reg_sel: sel};
    host_wr_data   = data;
    host_cmd_valid = 1'b1;
    next_cycle();
    host_cmd_valid = 1'b0;
    host_cmd.wr    = 1'b0;
    repeat (2) next_cycle();
  endtask

  task automatic expect_reg(input string what, input bit to_int, input logic [3:0] sel,
                            input logic [3:0] index, input logic [31:0] exp);
    next_cycle();
    host_cmd = '{wr: 1'b0, to_int: to_int, to_sched: 1'b1, spare: '0, index: index,
                 reg_sel: sel};
    // Command register and then readback register
    repeat (3) next_cycle();
    assert (host_rd_data == exp) else report_mismatch(what, exp, host_rd_data);
  endtask

  task automatic send_ctrl(input logic [3:0] msg_type, input int core, input int slot);
    next_cycle();
    ctrl_msg          = '0;
    ctrl_msg.msg_type = msg_type;
    ctrl_msg.slot     = slot_t'(slot);
    ctrl_core         = core_id_t'(core);
    ctrl_valid        = 1'b1;
    next_cycle();
    ctrl_valid = 1'b0;
    repeat (3) next_cycle();
  endtask

  task automatic slot_init(input int core, input int n);
    send_ctrl(`SCHED_MSG_SLOT_INIT, core, n);
    free_q[core].delete();
    for (int s = 1; s <= n && s <= `SCHED_SLOT_COUNT; s++) begin
      free_q[core].push_back(s);
    end
  endtask

  task automatic slot_return(input int core, input int slot);
    if (free_q[core].size() == `SCHED_SLOT_COUNT) begin
      err_expect++;
    end else begin
      free_q[core].push_back(slot);
    end
    send_ctrl(`SCHED_MSG_SLOT_RETURN, core, slot);
    assert (err_pulses == err_expect) else report_mismatch("slot_err pulses", err_expect,
                                                           err_pulses);
  endtask

  // Offers n hashes on each selected interface and holds each until accepted
  task automatic send_hashes(input int n, input int core, input if_mask_t ifs);
    int base [IFS];
    bit done;
    for (int i = 0; i < IFS; i++) begin
      base[i] = in_count[i];
    end
    done = 1'b0;
    while (!done) begin
      next_cycle();
      done = 1'b1;
      for (int i = 0; i < IFS; i++) begin
        if (!ifs[i] || (in_count[i] - base[i]) >= n) begin
          hash_valid[i] = 1'b0;
        end else begin
          done = 1'b0;
          if (!hash_valid[i] || took[i]) begin
            hash[i]       = make_hash(core);
            hash_valid[i] = 1'b1;
          end
        end
      end
    end
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (pending() != 0) begin
      assert (cycles < DRAIN_LIMIT) else abort_run("descriptors did not come out in time");
      next_cycle();
      cycles++;
    end
    // Every accepted hash is out and no further descriptor may be waiting
    assert (desc_valid == '0)
      else report_mismatch("descriptor valid after drain", 64'd0, desc_valid);
  endtask

  task automatic host_reg_test();
    logic [7:0] en;
    logic [7:0] inc;
    test_name = "host_regs";
    en = 8'hA5;
    host_write(1'b0, `SCHED_REG_ENABLED, 4'd0, 32'(en));
    inc = 8'hFF & en;
    host_write(1'b0, `SCHED_REG_INCOME, 4'd0, 32'hFF);
    expect_reg("enabled", 1'b0, `SCHED_REG_ENABLED, 4'd0, 32'(en));
    expect_reg("income", 1'b0, `SCHED_REG_INCOME, 4'd0, 32'(inc));
    en  = 8'h0F;
    inc = inc & en;
    host_write(1'b0, `SCHED_REG_ENABLED, 4'd0, 32'(en));
    expect_reg("income after enabled", 1'b0, `SCHED_REG_INCOME, 4'd0, 32'(inc));
    expect_reg("unknown core reg", 1'b0, 4'd9, 4'd0, `SCHED_RD_DEFAULT);
    expect_reg("unknown if reg", 1'b1, 4'd7, 4'd0, `SCHED_RD_DEFAULT);
    host_write(1'b0, `SCHED_REG_ENABLED, 4'd0, 32'hFF);
  endtask

  task automatic slot_count_test();
    int n;
    test_name = "slot_count";
    for (int c = 0; c < CORES; c++) begin
      n = 1 + int'(rand_bits(5));
      slot_init(c, n);
      expect_reg("init count", 1'b0, `SCHED_REG_SLOT_COUNT, 4'(c), 32'(n));
    end
    host_write(1'b0, `SCHED_REG_FLUSH, 4'd0, 32'hFF);
    for (int c = 0; c < CORES; c++) begin
      free_q[c].delete();
      expect_reg("flush count", 1'b0, `SCHED_REG_SLOT_COUNT, 4'(c), 32'd0);
    end
    slot_return(2, 17);
    expect_reg("return count", 1'b0, `SCHED_REG_SLOT_COUNT, 4'd2, 32'd1);
  endtask

  task automatic drop_test();
    int base;
    test_name = "drop";
    // Core 3 leaves the income set and interface 1 goes over the limit
    host_write(1'b0, `SCHED_REG_INCOME, 4'd0, 32'hF7);
    host_write(1'b1, `SCHED_REG_DROP_LIMIT, 4'd0, 32'd100);
    line_count[1] = line_count_t'(100 + rand_bits(4));
    repeat (4) next_cycle();
    drop_expect = 3'b010;
    send_hashes(5, 3, 3'b010);
    wait_drained();
    expect_reg("drop count", 1'b1, `SCHED_REG_DROP_COUNT, 4'd1, 32'd5);
    expect_reg("idle drop count", 1'b1, `SCHED_REG_DROP_COUNT, 4'd0, 32'd0);
    // Below the limit the request waits until the core takes traffic again
    drop_expect   = '0;
    line_count[1] = line_count_t'(99);
    repeat (4) next_cycle();
    base = out_count[1];
    send_hashes(1, 3, 3'b010);
    repeat (40) next_cycle();
    assert (out_count[1] == base) else report_mismatch("waiting request", base, out_count[1]);
    host_write(1'b0, `SCHED_REG_INCOME, 4'd0, 32'hFF);
    wait_drained();
  endtask

  initial begin
    lfsr           = 32'd72284;
    rst_r          = 1'b1;
    hash           = '0;
    hash_valid     = '0;
    desc_ready     = '1;
    line_count     = '0;
    ctrl_msg       = '0;
    ctrl_core      = '0;
    ctrl_valid     = 1'b0;
    host_cmd       = '0;
    host_wr_data   = '0;
    host_cmd_valid = 1'b0;
    took           = '0;
    drop_expect    = '0;
    err_pulses     = 0;
    err_expect     = 0;
    exact_slots    = 1'b1;
    ready_random   = 1'b0;
    in_count       = '{default: 0};
    out_count      = '{default: 0};
    repeat (4) @(negedge clk);
    rst_r = 1'b0;

    host_reg_test();
    slot_count_test();

    test_name = "alloc";
    host_write(1'b0, `SCHED_REG_INCOME, 4'd0, 32'hFF);
    for (int c = 0; c < CORES; c++) begin
      slot_init(c, 32);
    end
    send_hashes(20, -1, '1);
    wait_drained();

    drop_test();

    test_name = "stall";
    for (int c = 0; c < CORES; c++) begin
      slot_init(c, 32);
    end
    exact_slots  = 1'b0;
    ready_random = 1'b1;
    send_hashes(20, -1, '1);
    wait_drained();
    ready_random = 1'b0;
    exact_slots  = 1'b1;

    // Returned slots queue up behind the initial ones
    test_name = "reuse";
    slot_init(5, 2);
    slot_return(5, 20);
    slot_return(5, 9);
    expect_reg("reuse count", 1'b0, `SCHED_REG_SLOT_COUNT, 4'd5, 32'd4);
    send_hashes(4, 5, 3'b100);
    wait_drained();
    slot_init(6, 32);
    slot_return(6, 7);
    expect_reg("full count", 1'b0, `SCHED_REG_SLOT_COUNT, 4'd6, 32'd32);

    $display("test passed");
    $finish;
  end

  initial begin
    #(TEST_CYCLES * 4 * 2);
    abort_run("watchdog timeout, the tests did not finish");
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the rx_scheduler testbench with Verilator
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rx_scheduler_tb \
  -f all.f -o sim_rx_scheduler > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_rx_scheduler > sim.log 2>&1 || echo "test failed" >> sim.log
cat sim.log
grep -q "test failed" sim.log && { echo "FAILED"; exit 1; } || { echo "PASSED"; exit 0; }
